//--- flist.f
+incdir+logic
logic/coherence_pkg.sv
logic/line_store.sv
logic/coherency_unit.sv
logic/bus_ctrl.sv
logic/coherent_pair_top.sv
verification/tb_clock.sv
verification/tb_coherent_pair.sv

//--- logic/bus_ctrl.sv
`timescale 1ns/10ps

`include "coherence_cfg.svh"

module bus_ctrl import coherence_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  bus_req_t   req0,
    input  bus_req_t   req1,
    output bus_rsp_t   rsp0,
    output bus_rsp_t   rsp1,
    output snoop_req_t snp0,
    output snoop_req_t snp1,
    input  snoop_rsp_t snp_ans0,
    input  snoop_rsp_t snp_ans1
);
    localparam int MEM_WORDS = 1 << `COH_ADDR_W;

    word_t      mem_q [MEM_WORDS];
    logic       busy_q;
    logic       gnt_q;                                      // Owner now, last owner when idle
    logic [1:0] phase_q;
    snoop_rsp_t ans_q;

    bus_req_t   cur_req;
    snoop_rsp_t cur_ans;
    snoop_req_t snp_out;
    logic       is_snoop_op;
    logic       finish;
    logic       any_req;
    logic       grant_next;
    word_t      rsp_data;
    logic       rsp_excl;

    assign cur_req     = gnt_q ? req1 : req0;
    assign cur_ans     = gnt_q ? snp_ans0 : snp_ans1;      // Answer comes from the peer
    assign is_snoop_op = (cur_req.op == BUS_RD) || (cur_req.op == BUS_RDX);
    assign finish      = busy_q && ((cur_req.op == BUS_WB) ? (phase_q == 2'd0)
                                                           : (phase_q == 2'd2));

    assign any_req    = (req0.op != BUS_NONE) || (req1.op != BUS_NONE);
    // Both asking means the unit not served last time wins
    assign grant_next = (req0.op != BUS_NONE && req1.op != BUS_NONE) ? !gnt_q
                                                                     : (req1.op != BUS_NONE);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy_q  <= 1'b0;
            gnt_q   <= 1'b1;                                // Unit 0 goes first
            phase_q <= 2'd0;
        end else if (!busy_q) begin
            if (any_req) begin
                busy_q  <= 1'b1;
                gnt_q   <= grant_next;
                phase_q <= 2'd0;
            end
        end else begin
            phase_q <= phase_q + 2'd1;
            if (finish) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (busy_q && phase_q == 2'd1) begin
            ans_q <= cur_ans;
        end
    end

    // Memory takes writebacks and dirty interventions as the transaction ends
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= word_t'(`COH_MEM_INIT + i);
            end
        end else if (finish) begin
            if (cur_req.op == BUS_WB) begin
                mem_q[cur_req.addr] <= cur_req.wdata;
            end else if (ans_q.dirty) begin
                mem_q[cur_req.addr] <= ans_q.data;
            end
        end
    end

    // Snoop is up through issue and answer phases
    always_comb begin
        snp_out.valid = busy_q && is_snoop_op && (phase_q != 2'd2);
        snp_out.addr  = cur_req.addr;
        snp_out.inv   = (cur_req.op == BUS_RDX);
        snp0          = '0;
        snp1          = '0;
        if (gnt_q) begin
            snp0 = snp_out;
        end else begin
            snp1 = snp_out;
        end
    end

    assign rsp_data = ans_q.dirty ? ans_q.data : mem_q[cur_req.addr];
    assign rsp_excl = is_snoop_op && !ans_q.hit;           // Peer has no copy

    always_comb begin
        rsp0.dwait     = !(finish && !gnt_q);
        rsp0.exclusive = rsp_excl;
        rsp0.rdata     = rsp_data;
        rsp1.dwait     = !(finish && gnt_q);
        rsp1.exclusive = rsp_excl;
        rsp1.rdata     = rsp_data;
    end

    // Only a unit still holding its request sees dwait drop
    a_finish_has_req: assert property (@(posedge CLK) disable iff (!nRST)
        (rsp0.dwait || req0.op != BUS_NONE) && (rsp1.dwait || req1.op != BUS_NONE));

endmodule

//--- logic/coherence_cfg.svh
`ifndef COHERENCE_CFG_SVH
`define COHERENCE_CFG_SVH

// Word address width, one word per line
`define COH_ADDR_W 8

// Data word width
`define COH_DATA_W 32

// Lines in each direct-mapped store, power of two
`define COH_LINES 8

// Backing memory word n resets to this base plus n
`define COH_MEM_INIT 32'h1000_0000

`endif

//--- logic/coherence_pkg.sv
`include "coherence_cfg.svh"

package coherence_pkg;

    localparam int NUM_LINES = `COH_LINES;
    localparam int IDX_W     = $clog2(`COH_LINES);        // Low address bits pick the line
    localparam int TAG_W     = `COH_ADDR_W - IDX_W;

    typedef logic [`COH_ADDR_W-1:0] addr_t;
    typedef logic [`COH_DATA_W-1:0] word_t;

    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_t;

    typedef enum logic [1:0] {
        BUS_NONE,
        BUS_RD,                                             // Read for sharing
        BUS_RDX,                                            // Read for ownership
        BUS_WB                                              // Victim writeback
    } bus_op_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        BUS_REQ,
        SNOOP_ANS
    } ctrl_state_t;

    typedef struct packed {
        bus_op_t op;
        addr_t   addr;
        word_t   wdata;
    } bus_req_t;

    typedef struct packed {
        logic  dwait;
        logic  exclusive;                                   // Line arrives Exclusive
        word_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        logic  inv;                                         // Peer wants ownership
    } snoop_req_t;

    typedef struct packed {
        logic  hit;
        logic  dirty;
        word_t data;
    } snoop_rsp_t;

endpackage

//--- logic/coherency_unit.sv
`timescale 1ns/10ps

module coherency_unit import coherence_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       ren,
    input  logic       wen,
    input  addr_t      addr,
    input  word_t      wdata,
    output word_t      rdata,
    output logic       done,
    output bus_req_t   bus_req,
    input  bus_rsp_t   bus_rsp,
    input  snoop_req_t snoop_req,
    output snoop_rsp_t snoop_rsp
);
    ctrl_state_t state;
    ctrl_state_t next_state;

    logic  lookup_hit;
    mesi_t lookup_state;
    word_t lookup_data;
    addr_t victim_addr;
    logic  fill_en;
    mesi_t fill_state;
    word_t fill_data;
    logic  snp_hit;
    mesi_t snp_state;
    word_t snp_data;
    logic  snp_update;
    logic  access;
    logic  write_hit;
    logic  hit_done;

    assign access    = ren || wen;
    assign write_hit = lookup_hit && (lookup_state == MODIFIED || lookup_state == EXCLUSIVE);
    assign hit_done  = (ren && lookup_hit) || (wen && write_hit);

    line_store u_store (
        .CLK           (CLK),
        .nRST          (nRST),
        .cpu_addr      (addr),
        .lookup_hit    (lookup_hit),
        .lookup_state  (lookup_state),
        .lookup_data   (lookup_data),
        .victim_addr   (victim_addr),
        .fill_en       (fill_en),
        .fill_state    (fill_state),
        .fill_data     (fill_data),
        .snp_addr      (snoop_req.addr),
        .snp_hit       (snp_hit),
        .snp_state     (snp_state),
        .snp_data      (snp_data),
        .snp_update    (snp_update),
        .snp_new_state (snoop_req.inv ? INVALID : SHARED)
    );

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // A snoop pulls the FSM out of any waiting state, the access restarts from IDLE
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (snoop_req.valid) begin
                    next_state = SNOOP_ANS;
                end else if (access) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (snoop_req.valid) begin
                    next_state = SNOOP_ANS;
                end else if (hit_done) begin
                    next_state = IDLE;
                end else if (!lookup_hit && lookup_state == MODIFIED) begin
                    next_state = WRITEBACK;                     // Dirty victim goes first
                end else begin
                    next_state = BUS_REQ;                       // Miss or write to Shared
                end
            end
            WRITEBACK: begin
                if (snoop_req.valid) begin
                    next_state = SNOOP_ANS;
                end else if (!bus_rsp.dwait) begin
                    next_state = BUS_REQ;
                end
            end
            BUS_REQ: begin
                if (snoop_req.valid) begin
                    next_state = SNOOP_ANS;
                end else if (!bus_rsp.dwait) begin
                    next_state = IDLE;
                end
            end
            SNOOP_ANS: next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_comb begin
        bus_req.op      = BUS_NONE;
        bus_req.addr    = addr;
        bus_req.wdata   = wdata;
        rdata           = lookup_data;
        done            = 1'b0;
        fill_en         = 1'b0;
        fill_state      = MODIFIED;
        fill_data       = wdata;
        snoop_rsp.hit   = 1'b0;
        snoop_rsp.dirty = 1'b0;
        snoop_rsp.data  = snp_data;
        snp_update      = 1'b0;

        case (state)
            LOOKUP: begin
                if (!snoop_req.valid && hit_done) begin
                    done    = 1'b1;
                    fill_en = wen;                              // E or M becomes M
                end
            end
            WRITEBACK: begin
                bus_req.op    = BUS_WB;
                bus_req.addr  = victim_addr;
                bus_req.wdata = lookup_data;
            end
            BUS_REQ: begin
                bus_req.op = wen ? BUS_RDX : BUS_RD;
                if (!bus_rsp.dwait) begin
                    done    = 1'b1;
                    rdata   = bus_rsp.rdata;
                    fill_en = 1'b1;
                    if (!wen) begin
                        fill_state = bus_rsp.exclusive ? EXCLUSIVE : SHARED;
                        fill_data  = bus_rsp.rdata;
                    end
                end
            end
            SNOOP_ANS: begin
                snoop_rsp.hit   = snp_hit;
                snoop_rsp.dirty = snp_hit && (snp_state == MODIFIED);
                snp_update      = snp_hit;
            end
            default: begin
            end
        endcase
    end

    a_one_access: assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen));

    // Only a snoop may withdraw a pending request
    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        (bus_req.op != BUS_NONE && bus_rsp.dwait && !snoop_req.valid)
        |=> (bus_req.op == $past(bus_req.op)));

endmodule

//--- logic/coherent_pair_top.sv
`timescale 1ns/10ps

module coherent_pair_top import coherence_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  cpu0_ren,
    input  logic  cpu0_wen,
    input  addr_t cpu0_addr,
    input  word_t cpu0_wdata,
    output word_t cpu0_rdata,
    output logic  cpu0_done,
    input  logic  cpu1_ren,
    input  logic  cpu1_wen,
    input  addr_t cpu1_addr,
    input  word_t cpu1_wdata,
    output word_t cpu1_rdata,
    output logic  cpu1_done
);
    bus_req_t   req0;
    bus_req_t   req1;
    bus_rsp_t   rsp0;
    bus_rsp_t   rsp1;
    snoop_req_t snp0;
    snoop_req_t snp1;
    snoop_rsp_t snp_ans0;
    snoop_rsp_t snp_ans1;

    coherency_unit u_cu0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .ren       (cpu0_ren),
        .wen       (cpu0_wen),
        .addr      (cpu0_addr),
        .wdata     (cpu0_wdata),
        .rdata     (cpu0_rdata),
        .done      (cpu0_done),
        .bus_req   (req0),
        .bus_rsp   (rsp0),
        .snoop_req (snp0),
        .snoop_rsp (snp_ans0)
    );

    coherency_unit u_cu1 (
        .CLK       (CLK),
        .nRST      (nRST),
        .ren       (cpu1_ren),
        .wen       (cpu1_wen),
        .addr      (cpu1_addr),
        .wdata     (cpu1_wdata),
        .rdata     (cpu1_rdata),
        .done      (cpu1_done),
        .bus_req   (req1),
        .bus_rsp   (rsp1),
        .snoop_req (snp1),
        .snoop_rsp (snp_ans1)
    );

    bus_ctrl u_bus (
        .CLK      (CLK),
        .nRST     (nRST),
        .req0     (req0),
        .req1     (req1),
        .rsp0     (rsp0),
        .rsp1     (rsp1),
        .snp0     (snp0),
        .snp1     (snp1),
        .snp_ans0 (snp_ans0),
        .snp_ans1 (snp_ans1)
    );

endmodule

//--- logic/line_store.sv
`timescale 1ns/10ps

module line_store import coherence_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  addr_t cpu_addr,
    output logic  lookup_hit,
    output mesi_t lookup_state,
    output word_t lookup_data,
    output addr_t victim_addr,
    input  logic  fill_en,
    input  mesi_t fill_state,
    input  word_t fill_data,
    input  addr_t snp_addr,
    output logic  snp_hit,
    output mesi_t snp_state,
    output word_t snp_data,
    input  logic  snp_update,
    input  mesi_t snp_new_state
);
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    tag_t  tag_q   [NUM_LINES];
    mesi_t state_q [NUM_LINES];
    word_t data_q  [NUM_LINES];

    idx_t cpu_idx;
    idx_t snp_idx;
    tag_t cpu_tag;
    tag_t snp_tag;

    assign cpu_idx = cpu_addr[IDX_W-1:0];
    assign cpu_tag = cpu_addr[IDX_W +: TAG_W];
    assign snp_idx = snp_addr[IDX_W-1:0];
    assign snp_tag = snp_addr[IDX_W +: TAG_W];

    // Raw state of the indexed line, also read as the victim state on a miss
    assign lookup_state = state_q[cpu_idx];
    assign lookup_data  = data_q[cpu_idx];
    assign lookup_hit   = (state_q[cpu_idx] != INVALID) && (tag_q[cpu_idx] == cpu_tag);
    assign victim_addr  = {tag_q[cpu_idx], cpu_idx};   // Address of the occupant

    assign snp_state = state_q[snp_idx];
    assign snp_data  = data_q[snp_idx];
    assign snp_hit   = (state_q[snp_idx] != INVALID) && (tag_q[snp_idx] == snp_tag);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state_q[i] <= INVALID;
            end
        end else begin
            if (fill_en) begin
                state_q[cpu_idx] <= fill_state;
            end
            if (snp_update) begin
                state_q[snp_idx] <= snp_new_state;              // Downgrade only
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            tag_q[cpu_idx]  <= cpu_tag;
            data_q[cpu_idx] <= fill_data;
        end
    end

    // The unit FSM never fills and answers a snoop in one cycle
    a_no_port_clash: assert property (@(posedge CLK) disable iff (!nRST)
        !(fill_en && snp_update && (cpu_idx == snp_idx)));

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the coherent pair testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
FAIL_MSG="Done: errors found"
PASS_MSG="Done: no errors"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_coherent_pair -f flist.f -o tb_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q -F "$FAIL_MSG" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q -F "$PASS_MSG" "$SIM_LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "PASS"
exit 0

//--- verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic CLK,
    output logic nRST
);
    localparam int HALF_PERIOD = 5;                         // 10 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;                                        // Release away from the rising edge
    end

endmodule

//--- verification/tb_coherent_pair.sv
`timescale 1ns/10ps

`include "coherence_cfg.svh"

module tb_coherent_pair import coherence_pkg::*; ();
    localparam int   MEM_WORDS    = 1 << `COH_ADDR_W;
    localparam int   DONE_TIMEOUT = 50;
    localparam int   RANDOM_COUNT = 48;
    localparam logic P0 = 1'b0;
    localparam logic P1 = 1'b1;
    localparam logic RD = 1'b0;
    localparam logic WR = 1'b1;

    typedef struct packed {
        logic  proc;
        logic  wr;
        addr_t addr;
        word_t wdata;
        word_t exp;                                         // Read value from the model
        logic  exp_hit;                                     // Model predicts a local hit
    } entry_t;

    logic  CLK;
    logic  nRST;
    logic  cpu0_ren;
    logic  cpu0_wen;
    addr_t cpu0_addr;
    word_t cpu0_wdata;
    word_t cpu0_rdata;
    logic  cpu0_done;
    logic  cpu1_ren;
    logic  cpu1_wen;
    addr_t cpu1_addr;
    word_t cpu1_wdata;
    word_t cpu1_rdata;
    logic  cpu1_done;
    logic  cur_proc;
    logic  sel_done;
    logic  other_done;
    word_t sel_rdata;

    entry_t stim_q [$];

    // Reference model of memory and both line stores
    word_t ref_mem   [MEM_WORDS];
    addr_t ref_tag   [2][NUM_LINES];
    mesi_t ref_state [2][NUM_LINES];
    word_t ref_data  [2][NUM_LINES];

    tb_clock u_clock (
        .CLK  (CLK),
        .nRST (nRST)
    );

    coherent_pair_top u_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu0_ren   (cpu0_ren),
        .cpu0_wen   (cpu0_wen),
        .cpu0_addr  (cpu0_addr),
        .cpu0_wdata (cpu0_wdata),
        .cpu0_rdata (cpu0_rdata),
        .cpu0_done  (cpu0_done),
        .cpu1_ren   (cpu1_ren),
        .cpu1_wen   (cpu1_wen),
        .cpu1_addr  (cpu1_addr),
        .cpu1_wdata (cpu1_wdata),
        .cpu1_rdata (cpu1_rdata),
        .cpu1_done  (cpu1_done)
    );

    assign sel_done   = cur_proc ? cpu1_done : cpu0_done;
    assign other_done = cur_proc ? cpu0_done : cpu1_done;  // Idle side stays quiet
    assign sel_rdata  = cur_proc ? cpu1_rdata : cpu0_rdata;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s actual 0x%08h expected 0x%08h",
                                        name, actual, expected));
        end
    endtask

    task automatic init_model();
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = word_t'(`COH_MEM_INIT + i);
        end
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                ref_tag[p][i]   = '0;
                ref_state[p][i] = INVALID;
                ref_data[p][i]  = '0;
            end
        end
    endtask

    task automatic model_access(input logic p, input logic wr, input addr_t a,
                                input word_t wd, output word_t rd, output logic hit);
        int    me;
        int    peer;
        int    idx;
        logic  line_hit;
        logic  peer_hit;
        word_t src;
        me       = p ? 1 : 0;
        peer     = 1 - me;
        idx      = int'(a) % NUM_LINES;
        line_hit = (ref_state[me][idx] != INVALID) && (ref_tag[me][idx] == a);
        peer_hit = (ref_state[peer][idx] != INVALID) && (ref_tag[peer][idx] == a);
        rd       = wd;
        hit      = 1'b0;
        if (!wr && line_hit) begin
            rd  = ref_data[me][idx];
            hit = 1'b1;
        end else if (wr && line_hit && ref_state[me][idx] != SHARED) begin
            ref_state[me][idx] = MODIFIED;                  // E or M written locally
            ref_data[me][idx]  = wd;
            hit                = 1'b1;
        end else begin
            if (!line_hit && ref_state[me][idx] == MODIFIED) begin
                ref_mem[ref_tag[me][idx]] = ref_data[me][idx];
            end
            if (peer_hit && ref_state[peer][idx] == MODIFIED) begin
                ref_mem[a] = ref_data[peer][idx];           // Dirty intervention
            end
            src = ref_mem[a];
            if (peer_hit) begin
                ref_state[peer][idx] = wr ? INVALID : SHARED;
            end
            ref_tag[me][idx] = a;
            if (wr) begin
                ref_state[me][idx] = MODIFIED;
                ref_data[me][idx]  = wd;
            end else begin
                ref_state[me][idx] = peer_hit ? SHARED : EXCLUSIVE;
                ref_data[me][idx]  = src;
                rd                 = src;
            end
        end
    endtask

    task automatic add_entry(input logic p, input logic wr, input addr_t a, input word_t wd);
        entry_t e;
        word_t  rd;
        logic   hit;
        model_access(p, wr, a, wd, rd, hit);
        e.proc    = p;
        e.wr      = wr;
        e.addr    = a;
        e.wdata   = wd;
        e.exp     = rd;
        e.exp_hit = hit;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        addr_t       hot_addr [4];
        logic [31:0] seed;
        logic [31:0] pick;
        // Cold reads, then a shared copy
        add_entry(P0, RD, 8'h40, '0);
        add_entry(P1, RD, 8'h41, '0);
        add_entry(P1, RD, 8'h40, '0);
        add_entry(P0, RD, 8'h40, '0);
        add_entry(P0, WR, 8'h50, 32'hcafe_0050);
        add_entry(P1, RD, 8'h50, '0);                       // Peer holds it Modified
        add_entry(P0, RD, 8'h50, '0);
        // Ownership moves back and forth
        add_entry(P0, WR, 8'h60, 32'h0000_6001);
        add_entry(P1, WR, 8'h60, 32'h0000_6002);
        add_entry(P0, WR, 8'h60, 32'h0000_6003);
        add_entry(P1, RD, 8'h60, '0);
        add_entry(P0, RD, 8'h60, '0);
        add_entry(P1, WR, 8'h60, 32'h0000_6004);            // Upgrade from Shared
        add_entry(P0, RD, 8'h60, '0);
        // Same index, dirty victim
        add_entry(P0, WR, 8'h05, 32'hdead_0005);
        add_entry(P0, RD, 8'h0d, '0);
        add_entry(P0, RD, 8'h05, '0);
        add_entry(P1, RD, 8'h05, '0);
        add_entry(P1, RD, 8'h41, '0);
        add_entry(P1, RD, 8'h41, '0);
        add_entry(P0, RD, 8'h05, '0);
        hot_addr[0] = 8'h12;
        hot_addr[1] = 8'h22;                                // Shares index 2
        hot_addr[2] = 8'h13;
        hot_addr[3] = 8'h23;                                // Shares index 3
        seed = 32'h3f14_cce0;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            seed = lcg_next(seed);
            pick = seed;
            seed = lcg_next(seed);
            add_entry(pick[31], pick[30], hot_addr[pick[29:28]], seed);
        end
    endtask

    task automatic drive_idle();
        cpu0_ren   = 1'b0;
        cpu0_wen   = 1'b0;
        cpu0_addr  = '0;
        cpu0_wdata = '0;
        cpu1_ren   = 1'b0;
        cpu1_wen   = 1'b0;
        cpu1_addr  = '0;
        cpu1_wdata = '0;
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic apply_entry(input int n);
        entry_t e;
        int     edges;
        logic   seen;
        word_t  got;
        e = stim_q[n];
        drive_idle();
        cur_proc = e.proc;
        if (e.proc) begin
            cpu1_ren   = !e.wr;
            cpu1_wen   = e.wr;
            cpu1_addr  = e.addr;
            cpu1_wdata = e.wdata;
        end else begin
            cpu0_ren   = !e.wr;
            cpu0_wen   = e.wr;
            cpu0_addr  = e.addr;
            cpu0_wdata = e.wdata;
        end
        edges = 0;
        seen  = 1'b0;
        got   = '0;
        while (!seen) begin
            @(posedge CLK);
            edges++;
            @(negedge CLK);
            check_value($sformatf("cpu%0d_done", !e.proc), other_done, 32'd0);
            if (sel_done) begin
                seen = 1'b1;
                got  = sel_rdata;
            end else if (edges >= DONE_TIMEOUT) begin
                stop_with_failure($sformatf(
                    "no done from processor %0d on entry %0d within %0d cycles",
                    e.proc, n, DONE_TIMEOUT));
            end
        end
        @(posedge CLK);                                     // Edge that completes the access
        edges++;
        @(negedge CLK);
        drive_idle();
        if (!e.wr) begin
            check_value($sformatf("cpu%0d_rdata", e.proc), got, e.exp);
        end
        if (e.exp_hit) begin
            check_value($sformatf("cpu%0d_done latency", e.proc), edges, 32'd2);
        end
    endtask

    initial begin
        int cycles;
        drive_idle();
        cur_proc = 1'b0;
        init_model();
        build_table();
        cycles = 0;
        while (nRST !== 1'b1) begin
            @(negedge CLK);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                stop_with_failure("reset was never released");
            end
        end
        @(negedge CLK);
        for (int n = 0; n < stim_q.size(); n++) begin
            apply_entry(n);
        end
        $display("applied %0d entries", stim_q.size());
        $display("Done: no errors");
        $finish;
    end

endmodule
